// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_bch_decoder
LINT_TOP ?= bch_decoder
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_bch_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bch_decoder
	import bch_pkg::*;
();

	localparam int T = 2;
	localparam int LAT = 2 * T + 3; // cycles from driving start to seeing done
	localparam int RESET_CYCLES = 16;
	localparam int N_TESTS = 5;
	localparam int N_WORDS = 70; // words over all tests rounded up
	localparam int WATCH_CYCLES = N_TESTS * N_WORDS * (LAT + 4) + RESET_CYCLES + 200;
	localparam logic [8:0] GEN_POLY = 9'h1d1; // x^8 + x^7 + x^6 + x^4 + 1

	logic clk;
	logic rst_n;
	logic start;
	codeword_t codeword;
	logic busy;
	logic done;
	codeword_t corrected;
	logic [1:0] err_count;
	logic uncorrectable;

	logic [31:0] rng; // xorshift state
	int errors;
	int checks;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	bch_decoder #(.T(T)) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.codeword(codeword),
		.busy(busy),
		.done(done),
		.corrected(corrected),
		.err_count(err_count),
		.uncorrectable(uncorrectable)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// non systematic encoding gives m(x) * g(x) over GF(2)
	function automatic codeword_t encode(input logic [6:0] msg);
		codeword_t cw;
		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i])
				cw = cw ^ (codeword_t'(GEN_POLY) << i);
		end
		return cw;
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("ERR %0t ns: %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errs_before);
	endtask

	// steps one cycle at a time until done shows up or the limit runs out
	task automatic wait_done(inout int lat);
		while (!done && lat < 4 * LAT) begin
			@(posedge clk);
			#2;
			lat++;
		end
		if (!done) begin
			errors++;
			$display("no done pulse within %0d cycles of start, at %0t ns", lat, $time);
		end
	endtask

	// called 2 ns after an edge with busy low
	task automatic decode_word(input codeword_t word, output codeword_t got,
			output logic [1:0] got_cnt, output logic got_unc, output int lat);
		start = 1'b1;
		codeword = word;
		@(posedge clk);
		#2;
		start = 1'b0;
		lat = 1;
		wait_done(lat);
		got = corrected;
		got_cnt = err_count;
		got_unc = uncorrectable;
	endtask

	task automatic check_word(input codeword_t rx, input codeword_t cw, input logic [1:0] n_err);
		codeword_t got;
		logic [1:0] cnt;
		logic unc;
		int lat;
		decode_word(rx, got, cnt, unc, lat);
		checks++;
		if (lat != LAT)
			flag_error($sformatf("done after %0d cycles, expected %0d", lat, LAT));
		if (got !== cw)
			flag_error($sformatf("corrected %h, expected %h (received %h)", got, cw, rx));
		if (cnt !== n_err)
			flag_error($sformatf("err_count %0d, expected %0d", cnt, n_err));
		if (unc !== 1'b0)
			flag_error($sformatf("uncorrectable set for received %h", rx));
	endtask

	task automatic reset_test();
		int e0;
		e0 = errors;
		for (int c = 0; c < 8; c++) begin
			checks++;
			if (busy !== 1'b0)
				flag_error("busy is not 0 after reset");
			if (done !== 1'b0)
				flag_error("done is not 0 after reset");
			@(posedge clk);
			#2;
		end
		report_test("reset", e0);
	endtask

	task automatic no_error_test();
		codeword_t cw;
		int e0;
		e0 = errors;
		for (int k = 0; k < 20; k++) begin
			rng = xorshift32(rng);
			cw = encode(rng[6:0]);
			check_word(cw, cw, 2'd0);
		end
		report_test("no errors", e0);
	endtask

	task automatic single_error_test();
		codeword_t cw;
		int e0;
		e0 = errors;
		rng = xorshift32(rng);
		cw = encode(rng[6:0]);
		for (int p = 0; p < BCH_N; p++)
			check_word(cw ^ (codeword_t'(1) << p), cw, 2'd1);
		report_test("single errors", e0);
	endtask

	task automatic double_error_test();
		codeword_t cw;
		int p1;
		int p2;
		int e0;
		e0 = errors;
		for (int k = 0; k < 30; k++) begin
			rng = xorshift32(rng);
			cw = encode(rng[6:0]);
			rng = xorshift32(rng);
			p1 = int'(rng % 32'd15);
			rng = xorshift32(rng);
			p2 = (p1 + 1 + int'(rng % 32'd14)) % 15; // never equal to p1
			check_word(cw ^ (codeword_t'(1) << p1) ^ (codeword_t'(1) << p2), cw, 2'd2);
		end
		report_test("double errors", e0);
	endtask

	task automatic ignored_start_test();
		codeword_t a;
		int lat;
		int extra;
		int e0;
		e0 = errors;
		a = encode(7'h35);
		start = 1'b1;
		codeword = a;
		@(posedge clk);
		#2;
		checks++;
		if (busy !== 1'b1)
			flag_error("busy not high in the cycle after start");
		codeword = encode(7'h4a) ^ 15'h0001; // start stays high with another word
		@(posedge clk);
		#2;
		start = 1'b0;
		lat = 2;
		wait_done(lat);
		if (lat != LAT)
			flag_error($sformatf("done after %0d cycles, expected %0d", lat, LAT));
		if (corrected !== a)
			flag_error($sformatf("corrected %h, expected %h", corrected, a));
		extra = 0;
		repeat (3 * LAT) begin
			@(posedge clk);
			#2;
			if (done)
				extra++;
		end
		if (extra != 0)
			flag_error($sformatf("start while busy gave %0d extra done pulses", extra));
		report_test("ignored start", e0);
	endtask

	task automatic back_to_back_test();
		codeword_t cw_a;
		codeword_t cw_b;
		codeword_t results[$];
		int done_at[$];
		int start_b;
		int c;
		int e0;
		e0 = errors;
		cw_a = encode(7'h13);
		cw_b = encode(7'h6e);
		start_b = -1;
		c = 0;
		start = 1'b1;
		codeword = cw_a ^ 15'h0100;
		while (done_at.size() < 2 && c < 6 * LAT) begin
			@(posedge clk);
			#2;
			c++;
			start = 1'b0;
			if (done) begin
				done_at.push_back(c);
				results.push_back(corrected);
			end
			if (start_b < 0 && !busy) begin
				start = 1'b1; // second word in the first idle cycle
				codeword = cw_b ^ 15'h0012;
				start_b = c;
			end
		end
		checks++;
		if (done_at.size() != 2) begin
			errors++;
			$display("back to back words gave %0d done pulses instead of 2", done_at.size());
		end else begin
			if (start_b != 2 * T + 1)
				flag_error($sformatf("second start taken after %0d cycles", start_b));
			if (done_at[0] != LAT || done_at[1] - start_b != LAT)
				flag_error($sformatf("done pulses at %0d and %0d", done_at[0], done_at[1]));
			if (results[0] !== cw_a)
				flag_error($sformatf("first word %h, expected %h", results[0], cw_a));
			if (results[1] !== cw_b)
				flag_error($sformatf("second word %h, expected %h", results[1], cw_b));
		end
		report_test("back to back", e0);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		codeword = '0;
		rng = 32'd59;
		errors = 0;
		checks = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;
		reset_test();
		no_error_test();
		single_error_test();
		double_error_test();
		ignored_start_test();
		back_to_back_test();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// ends a run that hangs somewhere in the tests
	initial begin
		repeat (WATCH_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: rtl/bch_chien.sv
`timescale 1ns/1ns
`default_nettype none

module bch_chien
	import gf_pkg::*, bch_pkg::*;
#(
	parameter int T = 2
) (
	input logic clk,
	input logic rst_n,
	input logic key_done,
	input bch_key_t key,
	output bch_loc_t loc,
	output logic loc_valid
);

	gf_elem_t [0:BCH_N-1] value; // sigma(alpha^-i) for every position
	logic [BCH_N-1:0] mask_next;
	logic [1:0] roots_next;

	always_comb begin
		for (int i = 0; i < BCH_N; i++) begin
			value[i] = '0;
			for (int j = 0; j <= T; j++)
				value[i] = value[i] ^ gf_mul(key.sigma[j], gf_alpha(BCH_N - (i * j) % BCH_N));
			mask_next[i] = (value[i] == '0); // a root marks an error at position i
		end
	end

	always_comb begin
		roots_next = 2'd0;
		for (int i = 0; i < BCH_N; i++) begin
			if (mask_next[i] && roots_next != 2'd3)
				roots_next = roots_next + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			loc_valid <= 1'b0;
		else
			loc_valid <= key_done;
	end

	always_ff @(posedge clk) begin
		if (key_done) begin
			loc.codeword <= key.codeword;
			loc.err_mask <= mask_next;
			loc.err_count <= key.err_count;
			loc.root_count <= roots_next;
		end
	end

endmodule

`default_nettype wire

// File: rtl/bch_correct.sv
`timescale 1ns/1ns
`default_nettype none

module bch_correct
	import gf_pkg::*, bch_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic loc_valid,
	input bch_loc_t loc,
	output codeword_t corrected,
	output logic [1:0] err_count,
	output logic uncorrectable,
	output logic done
);

	codeword_t fixed; // word with the located bits flipped
	logic bad;

	assign fixed = loc.codeword ^ loc.err_mask;

	// a locator whose roots do not match its degree means too many errors
	assign bad = (loc.root_count != loc.err_count);

	always_ff @(posedge clk) begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= loc_valid;
	end

	always_ff @(posedge clk) begin
		if (loc_valid) begin
			corrected <= fixed;
			err_count <= loc.err_count;
			uncorrectable <= bad;
		end
	end

endmodule

`default_nettype wire

// File: rtl/bch_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module bch_decoder
	import gf_pkg::*, bch_pkg::*;
#(
	parameter int T = 2
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input codeword_t codeword,
	output logic busy,
	output logic done,
	output codeword_t corrected,
	output logic [1:0] err_count,
	output logic uncorrectable
);

	logic start_ok; // start taken only while the front end is idle
	logic syn_busy;
	logic key_busy;
	logic syn_valid;
	logic key_done;
	logic loc_valid;
	bch_syn_t syn;
	bch_key_t key;
	bch_loc_t loc;

	assign start_ok = start && !busy;
	assign busy = syn_busy || key_busy;

	bch_syndrome #(.T(T)) i_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.start(start_ok),
		.codeword(codeword),
		.busy(syn_busy),
		.syn(syn),
		.syn_valid(syn_valid)
	);

	bch_key_bma #(.T(T)) i_key (
		.clk(clk),
		.rst_n(rst_n),
		.syn_valid(syn_valid),
		.syn(syn),
		.busy(key_busy),
		.key(key),
		.key_done(key_done)
	);

	bch_chien #(.T(T)) i_chien (
		.clk(clk),
		.rst_n(rst_n),
		.key_done(key_done),
		.key(key),
		.loc(loc),
		.loc_valid(loc_valid)
	);

	bch_correct i_correct (
		.clk(clk),
		.rst_n(rst_n),
		.loc_valid(loc_valid),
		.loc(loc),
		.corrected(corrected),
		.err_count(err_count),
		.uncorrectable(uncorrectable),
		.done(done)
	);

endmodule

`default_nettype wire

// File: rtl/bch_key_bma.sv
`timescale 1ns/1ns
`default_nettype none

module bch_key_bma
	import gf_pkg::*, bch_pkg::*;
#(
	parameter int T = 2
) (
	input logic clk,
	input logic rst_n,
	input logic syn_valid,
	input bch_syn_t syn,
	output logic busy,
	output bch_key_t key,
	output logic key_done
);

	localparam int NSH = 2 * BCH_T_MAX + 1; // syndromes plus one zero slot for S0

	gf_elem_t [0:BCH_T_MAX] sigma; // current locator
	gf_elem_t [0:BCH_T_MAX] beta; // correction polynomial
	gf_elem_t [0:BCH_T_MAX] dr_beta; // d_r * beta, formed in the even cycle
	gf_elem_t [0:NSH-1] shuf; // shuf[i] holds S(2r+1-i)
	gf_elem_t [0:NSH-1] syn_ext; // S0 = 0 followed by S1 and up
	gf_elem_t s1;
	gf_elem_t d_r; // discrepancy of this iteration
	gf_elem_t d_p; // discrepancy of the last length change
	gf_elem_t d_r_next;
	logic [1:0] r; // iteration index
	logic [2:0] l; // register length, may exceed T on bad words
	logic phase; // 0 is the discrepancy cycle, 1 the update cycle
	logic bsel;

	assign s1 = syn.syn[0];
	assign syn_ext = {gf_elem_t'(0), syn.syn};

	// length changes when the discrepancy is nonzero and r >= L
	assign bsel = (d_r != '0) && ({1'b0, r} >= l);

	always_comb begin
		d_r_next = '0;
		for (int i = 0; i <= T; i++)
			d_r_next = d_r_next ^ gf_mul(sigma[i], shuf[i]);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			phase <= 1'b0;
			r <= 2'd0;
			key_done <= 1'b0;
		end else begin
			key_done <= 1'b0;
			if (syn_valid) begin
				busy <= 1'b1;
				phase <= 1'b0;
				r <= 2'd1; // iteration 0 is folded into the load
			end else if (busy) begin
				if (r == 2'(T)) begin
					busy <= 1'b0;
					key_done <= 1'b1;
				end else begin
					phase <= ~phase;
					if (phase)
						r <= r + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (syn_valid) begin
			// result of iteration 0 from sigma = 1, beta = x, d_p = 1, L = 0
			for (int i = 0; i <= BCH_T_MAX; i++) begin
				sigma[i] <= (i == 0) ? gf_elem_t'(1) : (i == 1) ? s1 : '0;
				beta[i] <= (i <= T && i == ((s1 != '0) ? 2 : 3)) ? gf_elem_t'(1) : '0;
			end
			d_p <= (s1 != '0) ? s1 : gf_elem_t'(1);
			l <= {2'b00, s1 != '0};
			for (int k = 0; k < NSH; k++)
				shuf[k] <= syn_ext[(3 + NSH - k) % NSH]; // lined up for r = 1
		end else if (busy) begin
			if (r == 2'(T)) begin
				key.codeword <= syn.codeword;
				key.sigma <= sigma;
				key.err_count <= (l > 3'd3) ? 2'd3 : l[1:0];
			end else if (!phase) begin
				d_r <= d_r_next;
				for (int i = 0; i <= T; i++)
					dr_beta[i] <= gf_mul(d_r_next, beta[i]);
			end else begin
				// sigma = d_p * sigma + d_r * beta
				for (int i = 0; i <= T; i++)
					sigma[i] <= gf_mul(d_p, sigma[i]) ^ dr_beta[i];
				// beta = x^2 times the old sigma or the old beta
				beta[0] <= '0;
				beta[1] <= '0;
				for (int i = 2; i <= T; i++)
					beta[i] <= bsel ? sigma[i-2] : beta[i-2];
				if (bsel) begin
					d_p <= d_r;
					l <= {r, 1'b1} - l; // L = 2r + 1 - L
				end
				for (int k = 0; k < NSH; k++)
					shuf[k] <= shuf[(k + NSH - 2) % NSH]; // bring in the next two syndromes
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/bch_pkg.sv
`default_nettype none

package bch_pkg;

	import gf_pkg::*;

	localparam int BCH_N = 15; // code length
	localparam int BCH_T_MAX = 3; // arrays are sized for this correction capability

	typedef logic [BCH_N-1:0] codeword_t; // bit i is the coefficient of x^i

	// syndrome stage result, entries above 2T stay zero
	typedef struct packed {
		codeword_t codeword;
		gf_elem_t [0:2*BCH_T_MAX-1] syn; // S1 first
	} bch_syn_t;

	// key equation result
	typedef struct packed {
		codeword_t codeword;
		gf_elem_t [0:BCH_T_MAX] sigma; // sigma0 first
		logic [1:0] err_count; // degree of the locator
	} bch_key_t;

	// chien search result
	typedef struct packed {
		codeword_t codeword;
		logic [BCH_N-1:0] err_mask; // bits to flip
		logic [1:0] err_count;
		logic [1:0] root_count; // saturates at 3
	} bch_loc_t;

endpackage

`default_nettype wire

// File: rtl/bch_syndrome.sv
`timescale 1ns/1ns
`default_nettype none

module bch_syndrome
	import gf_pkg::*, bch_pkg::*;
#(
	parameter int T = 2
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input codeword_t codeword,
	output logic busy,
	output bch_syn_t syn,
	output logic syn_valid
);

	gf_elem_t [0:2*BCH_T_MAX-1] syn_next; // syndromes of the word at the input

	// S(j+1) is the sum of alpha^((j+1)*i) over every set bit i
	always_comb begin
		for (int j = 0; j < 2 * BCH_T_MAX; j++) begin
			syn_next[j] = '0;
			if (j < 2 * T) begin
				for (int i = 0; i < BCH_N; i++) begin
					if (codeword[i])
						syn_next[j] = syn_next[j] ^ gf_alpha((j + 1) * i);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			syn_valid <= 1'b0;
		else
			syn_valid <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			syn.codeword <= codeword; // word travels with its syndromes
			syn.syn <= syn_next;
		end
	end

	// the result is pending exactly while syn_valid is up
	assign busy = syn_valid;

endmodule

`default_nettype wire

// File: rtl/gf_pkg.sv
`default_nettype none

package gf_pkg;

	localparam int GF_M = 4; // bits per field element
	localparam logic [GF_M:0] GF_POLY = 5'b10011; // x^4 + x + 1
	localparam int GF_ORDER = (1 << GF_M) - 1; // alpha has order 15

	typedef logic [GF_M-1:0] gf_elem_t;

	// multiply by alpha, reducing by the field polynomial when the top bit falls out
	function automatic gf_elem_t gf_xtime(input gf_elem_t a);
		gf_elem_t r;
		r = {a[GF_M-2:0], 1'b0};
		if (a[GF_M-1])
			r = r ^ GF_POLY[GF_M-1:0];
		return r;
	endfunction

	// shift and add multiplier, msb of b first
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		p = '0;
		for (int k = GF_M - 1; k >= 0; k--) begin
			p = gf_xtime(p);
			if (b[k])
				p = p ^ a;
		end
		return p;
	endfunction

	// alpha^power, the exponent is reduced modulo the group order first
	function automatic gf_elem_t gf_alpha(input int unsigned power);
		gf_elem_t e;
		int unsigned n;
		n = power % GF_ORDER;
		e = gf_elem_t'(1);
		for (int k = 0; k < GF_ORDER - 1; k++) begin
			if (k < n)
				e = gf_xtime(e);
		end
		return e;
	endfunction

endpackage

`default_nettype wire

// File: src.f
rtl/gf_pkg.sv
rtl/bch_pkg.sv
rtl/bch_syndrome.sv
rtl/bch_key_bma.sv
rtl/bch_chien.sv
rtl/bch_correct.sv
rtl/bch_decoder.sv
bench/tb_bch_decoder.sv
